// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    // alu funct3, shared by OP and OP-IMM
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } insn_u;

endpackage

// ==== hdl/core_pkg.sv ====
package core_pkg;

    localparam int pc_w = 32;

    localparam logic [pc_w-1:0] reset_pc = '0;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_t;

    // jal counts as an always-taken kind
    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_jal
    } br_op_t;

endpackage

// ==== hdl/core_ifs.sv ====
`timescale 1ns/1ps

// execute register contents
interface ex_bus_if;
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic                  valid;
    logic [pc_w-1:0]       pc;
    alu_op_t               alu_op;
    logic [xlen-1:0]       op_a;
    logic [xlen-1:0]       op_b;
    logic [xlen-1:0]       rs2_val;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rd;
    br_op_t                br_op;

    modport issue (output valid, pc, alu_op, op_a, op_b, rs2_val, imm, rd, br_op);
    modport exec  (input  valid, pc, alu_op, op_a, op_b, rs2_val, imm, rd, br_op);
endinterface

// register file read ports
interface gpr_rd_if;
    import rv_isa_pkg::*;

    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       rd1;
    logic [xlen-1:0]       rd2;

    modport reader (output rs1, rs2, input rd1, rd2);
    modport file   (input rs1, rs2, output rd1, rd2);
endinterface

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cpu_en,
    input  logic [31:0]               insn,
    input  logic                      insn_valid,
    input  logic                      redirect,
    input  logic [core_pkg::pc_w-1:0] redirect_pc,
    output logic                      insn_ready,
    output logic [core_pkg::pc_w-1:0] pc,
    output logic                      id_valid,
    output logic [core_pkg::pc_w-1:0] id_pc,
    output logic [31:0]               id_insn
);
    import core_pkg::*;

    logic running;
    logic xfer;

    // no fetch while a redirect is pending
    assign insn_ready = cpu_en & running & ~redirect;
    assign xfer       = insn_valid & insn_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            pc       <= reset_pc;
            id_valid <= 1'b0;
        end else begin
            running <= 1'b1;
            if (redirect) begin
                pc <= redirect_pc;
            end else if (xfer) begin
                pc <= pc + pc_w'(4);
            end
            // xfer is low on redirect, so decode gets a bubble
            id_valid <= xfer;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            id_pc   <= pc;
            id_insn <= insn;
        end
    end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              id_valid,
    input  logic [core_pkg::pc_w-1:0]         id_pc,
    input  logic [31:0]                       id_insn,
    input  logic                              redirect,
    input  logic                              wb_we,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [rv_isa_pkg::xlen-1:0]       wb_data,
    gpr_rd_if.reader                          gpr,
    ex_bus_if.issue                           ex
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    insn_u           word;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic            legal;
    alu_op_t         alu_op;
    br_op_t          br_op;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] imm;

    assign word = id_insn;

    // immediates rebuilt from the r and i fields of the same word
    assign imm_i = {{(xlen-12){word.i.imm12[11]}}, word.i.imm12};
    assign imm_b = {{(xlen-12){word.r.funct7[6]}}, word.r.rd[0], word.r.funct7[5:0],
                    word.r.rd[4:1], 1'b0};
    assign imm_j = {{(xlen-20){word.i.imm12[11]}}, word.i.rs1, word.i.funct3,
                    word.i.imm12[0], word.i.imm12[10:1], 1'b0};
    assign imm_u = {word.i.imm12, word.i.rs1, word.i.funct3, 12'b0};

    assign gpr.rs1 = word.i.rs1;
    assign gpr.rs2 = word.r.rs2;

    // bypass from the instruction in execute
    assign rs1_val = (wb_we && wb_rd == word.i.rs1) ? wb_data : gpr.rd1;
    assign rs2_val = (wb_we && wb_rd == word.r.rs2) ? wb_data : gpr.rd2;

    always_comb begin
        legal  = 1'b1;
        alu_op = alu_add;
        br_op  = br_none;
        op_a   = rs1_val;
        op_b   = rs2_val;
        imm    = imm_i;
        case (word.r.opcode)
            op_op: begin
                case (word.r.funct3)
                    f3_add:  alu_op = (word.r.funct7 == f7_sub) ? alu_sub : alu_add;
                    f3_sll:  alu_op = alu_sll;
                    f3_slt:  alu_op = alu_slt;
                    f3_xor:  alu_op = alu_xor;
                    f3_srl:  alu_op = alu_srl;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: legal = 1'b0;
                endcase
            end
            op_imm: begin
                op_b = imm_i;
                case (word.i.funct3)
                    f3_add:  alu_op = alu_add;
                    f3_slt:  alu_op = alu_slt;
                    f3_xor:  alu_op = alu_xor;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: legal = 1'b0;
                endcase
            end
            op_lui: begin
                alu_op = alu_pass_b;
                op_b   = imm_u;
                imm    = imm_u;
            end
            op_branch: begin
                imm = imm_b;
                case (word.r.funct3)
                    f3_beq:  br_op = br_eq;
                    f3_bne:  br_op = br_ne;
                    f3_blt:  br_op = br_lt;
                    f3_bge:  br_op = br_ge;
                    default: legal = 1'b0;
                endcase
            end
            op_jal: begin
                br_op = br_jal;
                imm   = imm_j;
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= id_valid & legal & ~redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid) begin
            ex.pc      <= id_pc;
            ex.alu_op  <= alu_op;
            ex.op_a    <= op_a;
            ex.op_b    <= op_b;
            ex.rs2_val <= rs2_val;
            ex.imm     <= imm;
            ex.rd      <= word.r.rd;
            ex.br_op   <= br_op;
        end
    end

endmodule

// ==== hdl/gpr_file.sv ====
`timescale 1ns/1ps

module gpr_file (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              wb_we,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [rv_isa_pkg::xlen-1:0]       wb_data,
    gpr_rd_if.file                            gpr
);
    import rv_isa_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:2**reg_addr_w-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign gpr.rd1 = (gpr.rs1 == '0) ? '0 : regs[gpr.rs1];
    assign gpr.rd2 = (gpr.rs2 == '0) ? '0 : regs[gpr.rs2];

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
    ex_bus_if.exec                      ex,
    output logic [rv_isa_pkg::xlen-1:0] alu_result
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [4:0] shamt;
    logic       lt;

    assign shamt = ex.op_b[4:0];
    assign lt    = $signed(ex.op_a) < $signed(ex.op_b);

    always_comb begin
        case (ex.alu_op)
            alu_add:    alu_result = ex.op_a + ex.op_b;
            alu_sub:    alu_result = ex.op_a - ex.op_b;
            alu_and:    alu_result = ex.op_a & ex.op_b;
            alu_or:     alu_result = ex.op_a | ex.op_b;
            alu_xor:    alu_result = ex.op_a ^ ex.op_b;
            alu_slt:    alu_result = {{(xlen-1){1'b0}}, lt};
            alu_sll:    alu_result = ex.op_a << shamt;
            alu_srl:    alu_result = ex.op_a >> shamt;
            // lui immediate comes in on op_b
            alu_pass_b: alu_result = ex.op_b;
            default:    alu_result = '0;
        endcase
    end

endmodule

// ==== hdl/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    ex_bus_if.exec                    ex,
    output logic                      br_taken,
    output logic [core_pkg::pc_w-1:0] br_target
);
    import core_pkg::*;

    logic cond;

    always_comb begin
        case (ex.br_op)
            br_eq:   cond = (ex.op_a == ex.rs2_val);
            br_ne:   cond = (ex.op_a != ex.rs2_val);
            br_lt:   cond = ($signed(ex.op_a) < $signed(ex.rs2_val));
            br_ge:   cond = ($signed(ex.op_a) >= $signed(ex.rs2_val));
            br_jal:  cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign br_taken = ex.valid & cond;

    // same adder for b-type and j-type offsets
    assign br_target = ex.pc + ex.imm;

endmodule

// ==== hdl/writeback.sv ====
`timescale 1ns/1ps

module writeback (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rv_isa_pkg::xlen-1:0]       alu_result,
    input  logic                              br_taken,
    input  logic [core_pkg::pc_w-1:0]         br_target,
    ex_bus_if.exec                            ex,
    output logic                              redirect,
    output logic [core_pkg::pc_w-1:0]         redirect_pc,
    output logic                              wb_we,
    output logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_isa_pkg::xlen-1:0]       wb_data,
    output logic                              retire_valid,
    output logic [core_pkg::pc_w-1:0]         retire_pc,
    output logic [rv_isa_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_isa_pkg::xlen-1:0]       retire_data
);
    import core_pkg::*;

    logic is_branch;

    // conditional branches only, jal writes its link
    assign is_branch = ex.br_op inside {br_eq, br_ne, br_lt, br_ge};

    assign wb_we   = ex.valid & ~is_branch & (ex.rd != '0);
    assign wb_rd   = ex.rd;
    assign wb_data = (ex.br_op == br_jal) ? ex.pc + pc_w'(4) : alu_result;

    assign redirect    = br_taken;
    assign redirect_pc = br_target;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ex.valid;
        end
    end

    // branches and x0 writes report rd 0
    always_ff @(posedge clk) begin
        if (ex.valid) begin
            retire_pc   <= ex.pc;
            retire_rd   <= wb_we ? ex.rd : '0;
            retire_data <= wb_we ? wb_data : '0;
        end
    end

endmodule

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cpu_en,
    input  logic [31:0]                       insn,
    input  logic                              insn_valid,
    output logic                              insn_ready,
    output logic [rv_isa_pkg::xlen-1:0]       pc,
    output logic                              retire_valid,
    output logic [rv_isa_pkg::xlen-1:0]       retire_pc,
    output logic [rv_isa_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_isa_pkg::xlen-1:0]       retire_data
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic                  id_valid;
    logic [pc_w-1:0]       id_pc;
    logic [31:0]           id_insn;
    logic                  redirect;
    logic [pc_w-1:0]       redirect_pc;
    logic                  wb_we;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    logic [xlen-1:0]       alu_result;
    logic                  br_taken;
    logic [pc_w-1:0]       br_target;

    ex_bus_if ex_bus ();
    gpr_rd_if gpr_rd ();

    fetch_unit u_fetch_unit (
        .clk         (clk        ),
        .rst_n       (rst_n      ),
        .cpu_en      (cpu_en     ),
        .insn        (insn       ),
        .insn_valid  (insn_valid ),
        .redirect    (redirect   ),
        .redirect_pc (redirect_pc),
        .insn_ready  (insn_ready ),
        .pc          (pc         ),
        .id_valid    (id_valid   ),
        .id_pc       (id_pc      ),
        .id_insn     (id_insn    )
    );

    decode_stage u_decode_stage (
        .clk      (clk     ),
        .rst_n    (rst_n   ),
        .id_valid (id_valid),
        .id_pc    (id_pc   ),
        .id_insn  (id_insn ),
        .redirect (redirect),
        .wb_we    (wb_we   ),
        .wb_rd    (wb_rd   ),
        .wb_data  (wb_data ),
        .gpr      (gpr_rd  ),
        .ex       (ex_bus  )
    );

    gpr_file u_gpr_file (
        .clk     (clk    ),
        .rst_n   (rst_n  ),
        .wb_we   (wb_we  ),
        .wb_rd   (wb_rd  ),
        .wb_data (wb_data),
        .gpr     (gpr_rd )
    );

    alu u_alu (
        .ex         (ex_bus    ),
        .alu_result (alu_result)
    );

    branch_unit u_branch_unit (
        .ex        (ex_bus   ),
        .br_taken  (br_taken ),
        .br_target (br_target)
    );

    writeback u_writeback (
        .clk          (clk         ),
        .rst_n        (rst_n       ),
        .alu_result   (alu_result  ),
        .br_taken     (br_taken    ),
        .br_target    (br_target   ),
        .ex           (ex_bus      ),
        .redirect     (redirect    ),
        .redirect_pc  (redirect_pc ),
        .wb_we        (wb_we       ),
        .wb_rd        (wb_rd       ),
        .wb_data      (wb_data     ),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc   ),
        .retire_rd    (retire_rd   ),
        .retire_data  (retire_data )
    );

endmodule

// ==== testbench/rv_core_props.sv ====
`timescale 1ns/1ps

module rv_core_props (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        insn_valid,
    input logic                        insn_ready,
    input logic [rv_isa_pkg::xlen-1:0] pc,
    input logic                        redirect,
    input logic [core_pkg::pc_w-1:0]   redirect_pc,
    input logic                        id_valid,
    input logic [core_pkg::pc_w-1:0]   id_pc,
    input logic                        retire_valid,
    input logic [rv_isa_pkg::xlen-1:0] retire_pc
);
    int fail_count = 0;

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !insn_ready && !retire_valid)
        else begin
            $error("fetch or retire active during reset");
            fail_count++;
        end

    pc_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> pc == '0)
        else begin
            $error("pc is not the reset value after reset");
            fail_count++;
        end

    // pc moves only on a transfer or a redirect
    pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !(insn_valid && insn_ready) && !redirect |=> $stable(pc))
        else begin
            $error("pc changed without a transfer or redirect");
            fail_count++;
        end

    pc_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> pc == $past(redirect_pc))
        else begin
            $error("pc did not take the redirect target");
            fail_count++;
        end

    // the word sitting in decode at a redirect must never retire
    flushed_no_retire: assert property (@(posedge clk) disable iff (!rst_n)
        redirect && id_valid |-> ##2 !(retire_valid && retire_pc == $past(id_pc, 2)))
        else begin
            $error("flushed instruction retired");
            fail_count++;
        end

endmodule

bind rv_core_top rv_core_props rv_core_props_i (
    .clk          (clk         ),
    .rst_n        (rst_n       ),
    .insn_valid   (insn_valid  ),
    .insn_ready   (insn_ready  ),
    .pc           (pc          ),
    .redirect     (redirect    ),
    .redirect_pc  (redirect_pc ),
    .id_valid     (id_valid    ),
    .id_pc        (id_pc       ),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc   )
);

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

    localparam int prog_len    = 32;
    localparam int cycle_limit = prog_len * 4 + 50;

    typedef struct {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
        int          due;
    } retire_t;

    logic        clk;
    logic        rst_n;
    logic        cpu_en;
    logic [31:0] insn;
    logic        insn_valid;
    logic        insn_ready;
    logic [31:0] pc;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] prog [0:prog_len-1];
    logic [31:0] regs [0:31];
    logic [31:0] model_pc;
    logic [31:0] fetch_pc;
    logic [31:0] redir_pc;
    int          redir_cyc;
    int          cyc;
    integer      seed;
    retire_t     exp_q [$];

    rv_core_top rv_core_top_i (
        .clk          (clk         ),
        .rst_n        (rst_n       ),
        .cpu_en       (cpu_en      ),
        .insn         (insn        ),
        .insn_valid   (insn_valid  ),
        .insn_ready   (insn_ready  ),
        .pc           (pc          ),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc   ),
        .retire_rd    (retire_rd   ),
        .retire_data  (retire_data )
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // words past the program hold their address over opcode 0
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr < prog_len * 4) begin
            return prog[addr[31:2]];
        end
        return {addr[31:7] ^ {addr[6:0], 18'b0}, 7'b0};
    endfunction

    task automatic load_program();
        prog[0]  = enc_lui(5'd1, 20'h12345);
        prog[1]  = enc_i(3'b000, 5'd2, 5'd0, 12'd100);
        prog[2]  = enc_i(3'b000, 5'd3, 5'd2, 12'hff9);
        prog[3]  = enc_r(7'h00, 3'b000, 5'd4, 5'd3, 5'd2);
        prog[4]  = enc_r(7'h20, 3'b000, 5'd5, 5'd4, 5'd1);
        prog[5]  = enc_i(3'b100, 5'd6, 5'd5, 12'h0ff);
        prog[6]  = enc_i(3'b110, 5'd7, 5'd6, 12'h700);
        prog[7]  = enc_i(3'b111, 5'd8, 5'd7, 12'hff0);
        prog[8]  = enc_r(7'h00, 3'b010, 5'd9, 5'd5, 5'd2);
        prog[9]  = enc_i(3'b010, 5'd10, 5'd2, 12'd50);
        prog[10] = enc_r(7'h00, 3'b001, 5'd11, 5'd2, 5'd3);
        prog[11] = enc_r(7'h00, 3'b101, 5'd12, 5'd1, 5'd9);
        prog[12] = enc_r(7'h00, 3'b110, 5'd13, 5'd12, 5'd11);
        prog[13] = enc_r(7'h00, 3'b111, 5'd14, 5'd13, 5'd1);
        prog[14] = enc_r(7'h00, 3'b100, 5'd15, 5'd14, 5'd4);
        // x0 write, then a read of x0
        prog[15] = enc_i(3'b000, 5'd0, 5'd2, 12'd5);
        prog[16] = enc_r(7'h00, 3'b000, 5'd16, 5'd0, 5'd2);
        prog[17] = enc_b(3'b000, 5'd2, 5'd2, 13'd8);
        prog[18] = enc_i(3'b000, 5'd17, 5'd0, 12'd1);
        prog[19] = enc_b(3'b001, 5'd2, 5'd2, 13'd8);
        prog[20] = enc_b(3'b100, 5'd5, 5'd2, 13'd8);
        prog[21] = enc_i(3'b000, 5'd18, 5'd0, 12'd3);
        prog[22] = enc_b(3'b101, 5'd2, 5'd5, 13'd8);
        prog[23] = enc_i(3'b000, 5'd19, 5'd0, 12'd4);
        prog[24] = enc_b(3'b101, 5'd5, 5'd2, 13'd8);
        prog[25] = enc_jal(5'd20, 21'd8);
        prog[26] = enc_i(3'b000, 5'd21, 5'd0, 12'd6);
        prog[27] = enc_r(7'h00, 3'b000, 5'd22, 5'd20, 5'd16);
        prog[28] = enc_jal(5'd0, 21'd8);
        prog[29] = enc_i(3'b000, 5'd23, 5'd0, 12'd7);
        prog[30] = enc_b(3'b100, 5'd2, 5'd5, 13'd8);
        prog[31] = enc_i(3'b000, 5'd24, 5'd22, 12'hfff);
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        stop_run($sformatf("[FAIL] %0d ns: %s", $time, msg));
    endtask

    // architectural model of one instruction on the correct path
    task automatic execute(input logic [31:0] p, input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] next;
        logic        writes;
        logic        legal;
        logic        taken;
        retire_t     e;
        a      = regs[w[19:15]];
        b      = regs[w[24:20]];
        imm_i  = {{20{w[31]}}, w[31:20]};
        res    = '0;
        next   = p + 32'd4;
        writes = 1'b1;
        legal  = 1'b1;
        taken  = 1'b0;
        case (w[6:0])
            7'b0110011: begin
                case (w[14:12])
                    3'b000:  res = (w[31:25] == 7'b0100000) ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                    3'b100:  res = a ^ b;
                    3'b101:  res = a >> b[4:0];
                    3'b110:  res = a | b;
                    3'b111:  res = a & b;
                    default: legal = 1'b0;
                endcase
            end
            7'b0010011: begin
                case (w[14:12])
                    3'b000:  res = a + imm_i;
                    3'b010:  res = {31'b0, $signed(a) < $signed(imm_i)};
                    3'b100:  res = a ^ imm_i;
                    3'b110:  res = a | imm_i;
                    3'b111:  res = a & imm_i;
                    default: legal = 1'b0;
                endcase
            end
            7'b0110111: res = {w[31:12], 12'b0};
            7'b1100011: begin
                writes = 1'b0;
                case (w[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    default: legal = 1'b0;
                endcase
                if (taken) begin
                    next = p + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                taken = 1'b1;
                res   = p + 32'd4;
                next  = p + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: legal = 1'b0;
        endcase
        if (legal) begin
            if (taken) begin
                redir_cyc = cyc + 2;
                redir_pc  = next;
            end
            writes = writes && (w[11:7] != 5'd0);
            e.pc   = p;
            e.rd   = writes ? w[11:7] : 5'd0;
            e.data = writes ? res : 32'd0;
            e.due  = cyc + 3;
            exp_q.push_back(e);
            if (writes) begin
                regs[w[11:7]] = res;
            end
        end
        model_pc = next;
    endtask

    // all DUT outputs read here are their values before this edge
    task automatic step_cycle();
        retire_t e;
        logic    xfer;
        logic    redir;
        cyc++;
        if (cyc > cycle_limit) begin
            stop_run($sformatf("timeout: program did not finish in %0d cycles", cycle_limit));
        end
        assert (rv_core_top_i.rv_core_props_i.fail_count == 0)
            else stop_run("a bound protocol assertion failed");
        redir = (cyc == redir_cyc);
        assert (pc == fetch_pc)
            else report_mismatch($sformatf("pc %h, expected %h", pc, fetch_pc));
        if (redir) begin
            assert (!insn_ready)
                else report_mismatch("insn_ready high in a redirect cycle");
        end
        if (retire_valid) begin
            assert (exp_q.size() > 0)
                else report_mismatch($sformatf("unexpected retire at pc %h", retire_pc));
            e = exp_q.pop_front();
            assert (retire_pc == e.pc && retire_rd == e.rd && retire_data == e.data)
                else report_mismatch($sformatf("retire pc/rd/data %h/%0d/%h, expected %h/%0d/%h",
                    retire_pc, retire_rd, retire_data, e.pc, e.rd, e.data));
            assert (cyc == e.due)
                else report_mismatch($sformatf("pc %h retired at cycle %0d, expected %0d",
                    e.pc, cyc, e.due));
        end else if (exp_q.size() > 0) begin
            assert (exp_q[0].due != cyc)
                else report_mismatch($sformatf("missing retire for pc %h", exp_q[0].pc));
        end
        xfer = insn_valid && insn_ready;
        // a transfer off the model path is the word discarded after a taken branch
        if (xfer && pc == model_pc) begin
            execute(pc, fetch_word(pc));
        end
        if (redir) begin
            fetch_pc = redir_pc;
        end else if (xfer) begin
            fetch_pc = fetch_pc + 32'd4;
        end
        insn       <= fetch_word(fetch_pc);
        insn_valid <= ($random(seed) & 3) != 0;
    endtask

    initial begin
        seed = 32'he9a77482;
        load_program();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        model_pc   = '0;
        fetch_pc   = '0;
        redir_pc   = '0;
        redir_cyc  = -1;
        cyc        = 0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        cpu_en     = 1'b1;
        insn       = fetch_word(32'd0);
        insn_valid = 1'b0;
        repeat (2) @(posedge clk);
        rst_n      <= 1'b1;
        insn_valid <= ($random(seed) & 3) != 0;
        while (model_pc < prog_len * 4 || exp_q.size() != 0) begin
            @(posedge clk);
            step_cycle();
        end
        // let the bound checks see the last retire
        repeat (2) @(posedge clk);
        if (rv_core_top_i.rv_core_props_i.fail_count != 0) begin
            stop_run("a bound protocol assertion failed");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/core_ifs.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/gpr_file.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/writeback.sv
hdl/rv_core_top.sv
testbench/rv_core_props.sv
testbench/tb_rv_core.sv
